/* hw/usb_rx_pkg.sv */
package usb_rx_pkg;

	// System clocks in one full-speed bit period
	localparam int CLKS_PER_BIT = 8;

	// Counter value after an edge where the line is sampled
	localparam int SAMPLE_POINT = 3;

	// Consecutive decoded ones before a stuffed zero is expected
	localparam int STUFF_LIMIT = 6;

	// One received byte
	typedef logic [7:0] usb_byte_t;

	// Bit position inside a byte or clock phase inside a bit
	typedef logic [2:0] bit_count_t;

	// Decoded sync pattern KJKJKJKK seen LSB first
	localparam usb_byte_t SYNC_BYTE = 8'h80;

	// Receive FSM states
	typedef enum logic [2:0]
	{
		IDLE,
		SYNC,
		DATA,
		DONE,
		ERROR
	} rx_state_t;

endpackage

/* hw/usb_line_if.sv */
`timescale 1ns/10ps

interface usb_line_if;

	// Synchronized D+ level
	logic dp;

	// Single-cycle pulse on any change of dp
	logic edge_seen;

	// Both lines low
	logic eop;

	// Mid-bit sample strobe
	logic shift_enable;

	// Decoded bit and its qualifier
	logic d_orig;
	logic bit_valid;

	// Seven ones in a row
	logic stuff_err;

	modport sampler
	(
		output dp,
		output edge_seen,
		output eop
	);

	modport timer
	(
		input  edge_seen,
		output shift_enable
	);

	modport decoder
	(
		input  dp,
		input  eop,
		input  shift_enable,
		output d_orig,
		output bit_valid,
		output stuff_err
	);

	modport control
	(
		input edge_seen,
		input eop,
		input shift_enable,
		input d_orig,
		input bit_valid,
		input stuff_err
	);

endinterface

/* hw/line_sampler.sv */
`timescale 1ns/10ps

module line_sampler
(
	input logic tb_clk,
	input logic rst,
	input logic d_plus,
	input logic d_minus,
	usb_line_if.sampler line
);

	// First and second synchronizer stages
	logic dp_meta;
	logic dp_sync;
	logic dm_meta;
	logic dm_sync;

	// Last synchronized D+ for edge detection
	logic dp_prev;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			// Idle J state on the bus
			dp_meta <= 1'b1;
			dp_sync <= 1'b1;
			dm_meta <= 1'b0;
			dm_sync <= 1'b0;
			dp_prev <= 1'b1;
		end
		else
		begin
			dp_meta <= d_plus;
			dp_sync <= dp_meta;
			dm_meta <= d_minus;
			dm_sync <= dm_meta;
			dp_prev <= dp_sync;
		end
	end

	assign line.dp = dp_sync;

	// High for exactly one cycle after dp_sync toggles
	assign line.edge_seen = dp_sync ^ dp_prev;

	// SE0 on the synchronized pair
	assign line.eop = ~dp_sync & ~dm_sync;

endmodule

/* hw/bit_timer.sv */
`timescale 1ns/10ps

module bit_timer
(
	input logic tb_clk,
	input logic rst,
	input logic rcving,
	usb_line_if.timer line
);

	import usb_rx_pkg::*;

	// Clock phase inside the current bit
	bit_count_t phase_cnt;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			phase_cnt <= '0;
		end
		else if (line.edge_seen)
		begin
			// Resync the bit period to every line transition
			phase_cnt <= '0;
		end
		else if (phase_cnt == bit_count_t'(CLKS_PER_BIT - 1))
		begin
			// End of a bit period
			phase_cnt <= '0;
		end
		else
		begin
			phase_cnt <= phase_cnt + 1'b1;
		end
	end

	// Sample near mid-bit so a bit of seven to nine clocks still lands
	// inside the same period
	assign line.shift_enable = rcving && (phase_cnt == bit_count_t'(SAMPLE_POINT));

endmodule

/* hw/nrzi_decode.sv */
`timescale 1ns/10ps

module nrzi_decode
(
	input logic tb_clk,
	input logic rst,
	usb_line_if.decoder line
);

	import usb_rx_pkg::*;

	// Line level at the previous sample
	logic prev_level;

	// Run length of decoded ones
	bit_count_t ones_cnt;

	// Current bit is the one after a full run of ones
	logic stuff_slot;

	// No transition since the last sample
	logic level_same;

	assign level_same = (line.dp == prev_level);
	assign stuff_slot = (ones_cnt == bit_count_t'(STUFF_LIMIT));

	// NRZI decoding where a held level is a one
	assign line.d_orig = level_same;

	// Stuffed bits and the SE0 sample are not data
	assign line.bit_valid = line.shift_enable && !stuff_slot && !line.eop;

	// The slot that must hold a zero held a one instead
	assign line.stuff_err = line.shift_enable && stuff_slot && level_same && !line.eop;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			prev_level <= 1'b1;
		end
		else if (line.shift_enable)
		begin
			if (line.eop)
			begin
				// Back to J for the next packet
				prev_level <= 1'b1;
			end
			else
			begin
				prev_level <= line.dp;
			end
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			ones_cnt <= '0;
		end
		else if (line.shift_enable)
		begin
			if (line.eop || stuff_slot || !level_same)
			begin
				ones_cnt <= '0;
			end
			else
			begin
				ones_cnt <= ones_cnt + 1'b1;
			end
		end
	end

endmodule

/* hw/rx_control.sv */
`timescale 1ns/10ps

module rx_control
(
	input  logic tb_clk,
	input  logic rst,
	usb_line_if.control line,
	output logic rcving,
	output usb_rx_pkg::usb_byte_t rx_data,
	output logic rx_strobe,
	output logic rx_error,
	output logic packet_done
);

	import usb_rx_pkg::*;

	rx_state_t state;
	rx_state_t state_next;

	// Byte being assembled LSB first
	usb_byte_t shift_reg;
	usb_byte_t byte_next;

	// Number of bits already in shift_reg
	bit_count_t bit_cnt;

	logic byte_done;
	logic eop_sample;
	logic sync_ok;
	logic in_byte;

	// Shift register contents once the current bit is taken in
	assign byte_next = {line.d_orig, shift_reg[7:1]};

	// Eighth bit of a byte arrives this cycle
	assign byte_done = line.bit_valid && (bit_cnt == '1);

	// End of packet only counts at a sample point
	assign eop_sample = line.shift_enable && line.eop;

	assign sync_ok = (byte_next == SYNC_BYTE);
	assign in_byte = (bit_cnt != '0);

	// Timer runs from the first edge until the packet is closed
	assign rcving = (state == SYNC) || (state == DATA) || (state == ERROR);

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (line.edge_seen && !line.eop)
				begin
					state_next = SYNC;
				end
			end
			SYNC:
			begin
				if (eop_sample)
				begin
					state_next = DONE;
				end
				else if (line.stuff_err)
				begin
					state_next = ERROR;
				end
				else if (byte_done)
				begin
					state_next = sync_ok ? DATA : ERROR;
				end
			end
			DATA:
			begin
				if (eop_sample)
				begin
					state_next = DONE;
				end
				else if (line.stuff_err)
				begin
					state_next = ERROR;
				end
			end
			ERROR:
			begin
				// Drop everything until the packet ends
				if (eop_sample)
				begin
					state_next = DONE;
				end
			end
			DONE:
			begin
				// Hold off until the bus is back at J
				if (!line.eop)
				begin
					state_next = IDLE;
				end
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			state       <= IDLE;
			bit_cnt     <= '0;
			rx_strobe   <= 1'b0;
			rx_error    <= 1'b0;
			packet_done <= 1'b0;
		end
		else
		begin
			state <= state_next;

			if (state == IDLE)
			begin
				bit_cnt <= '0;
			end
			else if (line.bit_valid)
			begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			// Sync byte is checked but never presented
			rx_strobe <= (state == DATA) && byte_done;

			packet_done <= (state == DATA) && eop_sample && !in_byte;

			rx_error <= eop_sample &&
				((state == SYNC) || (state == ERROR) || ((state == DATA) && in_byte));
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (line.bit_valid)
		begin
			shift_reg <= byte_next;
		end
		if ((state == DATA) && byte_done)
		begin
			rx_data <= byte_next;
		end
	end

endmodule

/* hw/usb_rx_top.sv */
`timescale 1ns/10ps

module usb_rx_top
(
	input  logic       tb_clk,
	input  logic       rst,
	input  logic       d_plus,
	input  logic       d_minus,
	output logic [7:0] rx_data,
	output logic       rx_strobe,
	output logic       rx_error,
	output logic       packet_done,
	output logic       rcving
);

	// Line signals shared by the receive blocks
	usb_line_if line_bus ();

	line_sampler u_sampler
	(
		.tb_clk  (tb_clk),
		.rst     (rst),
		.d_plus  (d_plus),
		.d_minus (d_minus),
		.line    (line_bus.sampler)
	);

	bit_timer u_timer
	(
		.tb_clk (tb_clk),
		.rst    (rst),
		.rcving (rcving),
		.line   (line_bus.timer)
	);

	nrzi_decode u_decode
	(
		.tb_clk (tb_clk),
		.rst    (rst),
		.line   (line_bus.decoder)
	);

	// Packet framing and byte output
	rx_control u_control
	(
		.tb_clk      (tb_clk),
		.rst         (rst),
		.line        (line_bus.control),
		.rcving      (rcving),
		.rx_data     (rx_data),
		.rx_strobe   (rx_strobe),
		.rx_error    (rx_error),
		.packet_done (packet_done)
	);

endmodule

/* tests/tb_usb_rx.sv */
`timescale 1ns/10ps

module tb_usb_rx;

	import usb_rx_pkg::*;

	localparam int MAX_TESTS = 32;
	localparam int MAX_BYTES = 16;

	// J idle bits after each packet
	localparam int GAP_BITS = 4;

	logic       tb_clk;
	logic       rst;
	logic       d_plus;
	logic       d_minus;
	logic [7:0] rx_data;
	logic       rx_strobe;
	logic       rx_error;
	logic       packet_done;
	logic       rcving;

	// Vector table
	string      names[MAX_TESTS];
	logic [7:0] sync_v[MAX_TESTS];
	int         mode_v[MAX_TESTS];
	int         count_v[MAX_TESTS];
	logic [7:0] data_v[MAX_TESTS][MAX_BYTES];
	int         eop_v[MAX_TESTS];
	int         exp_bytes_v[MAX_TESTS];
	int         exp_err_v[MAX_TESTS];
	int         num_tests;

	// Collected by the monitor
	logic [7:0] got_q[$];
	int         done_cnt;
	int         err_cnt;
	int         rcv_cnt;

	integer     seed;
	int         cycle_cnt;
	int         cycle_limit;
	int         pass_cnt;
	int         fail_cnt;

	usb_rx_top dut
	(
		.tb_clk      (tb_clk),
		.rst         (rst),
		.d_plus      (d_plus),
		.d_minus     (d_minus),
		.rx_data     (rx_data),
		.rx_strobe   (rx_strobe),
		.rx_error    (rx_error),
		.packet_done (packet_done),
		.rcving      (rcving)
	);

	initial
	begin
		tb_clk = 1'b0;
		forever #5 tb_clk = ~tb_clk;
	end

	always @(posedge tb_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit)
		begin
			$display("Timeout after %0d cycles waiting for the end of a packet", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	// Registered outputs are settled at the falling edge
	always @(negedge tb_clk)
	begin
		if (!rst)
		begin
			if (rx_strobe)
			begin
				got_q.push_back(rx_data);
			end
			done_cnt = done_cnt + int'(packet_done);
			err_cnt = err_cnt + int'(rx_error);
			rcv_cnt = rcv_cnt + int'(rcving);
		end
	end

	task automatic load_vectors();
		int         fd;
		int         n;
		int         i;
		string      tok;
		string      rest;
		logic [7:0] b;
		num_tests = 0;
		fd = $fopen("tests/usb_rx_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open tests/usb_rx_vectors.txt");
			fail_cnt++;
		end
		else
		begin
			while (num_tests < MAX_TESTS && $fscanf(fd, "%s", tok) == 1)
			begin
				if (tok.substr(0, 0) == "#")
				begin
					n = $fgets(rest, fd);
				end
				else
				begin
					names[num_tests] = tok;
					n = $fscanf(fd, "%h %d %d", sync_v[num_tests], mode_v[num_tests],
						count_v[num_tests]);
					for (i = 0; i < count_v[num_tests]; i++)
					begin
						n = $fscanf(fd, "%h", b);
						data_v[num_tests][i] = b;
					end
					n = $fscanf(fd, "%d %d %d", eop_v[num_tests], exp_bytes_v[num_tests],
						exp_err_v[num_tests]);
					num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	// Line bits of all packets plus the idle check
	function automatic int vector_bits();
		int total;
		int t;
		total = 4;
		for (t = 0; t < num_tests; t++)
		begin
			total = total + 8 + eop_v[t] + 2 + GAP_BITS;
		end
		return total;
	endfunction

	task automatic hold_line(input logic dp, input logic dm, input int cycles);
		d_plus <= dp;
		d_minus <= dm;
		repeat (cycles) @(posedge tb_clk);
	endtask

	task automatic send_packet(input int idx);
		logic       bits[$];
		logic [7:0] cur;
		logic       level;
		int         ones;
		int         i;
		int         len;
		ones = 0;
		// Sync then data LSB first up to the end-of-packet offset
		for (i = 0; i < 8 + eop_v[idx]; i++)
		begin
			if (i < 8)
			begin
				cur = sync_v[idx] >> i;
			end
			else
			begin
				cur = data_v[idx][(i - 8) / 8] >> ((i - 8) % 8);
			end
			bits.push_back(cur[0]);
			ones = cur[0] ? ones + 1 : 0;
			// Mode 1 leaves the run of ones unstuffed
			if (ones == STUFF_LIMIT && mode_v[idx] != 1)
			begin
				bits.push_back(1'b0);
				ones = 0;
			end
		end
		level = 1'b1;
		for (i = 0; i < bits.size(); i++)
		begin
			// A zero toggles the NRZI line
			if (!bits[i])
			begin
				level = ~level;
			end
			len = CLKS_PER_BIT;
			if (mode_v[idx] == 2)
			begin
				len = (($random(seed) & 1) != 0) ? 9 : 7;
			end
			hold_line(level, ~level, len);
		end
		// Two bit times of SE0 and then back to J
		hold_line(1'b0, 1'b0, 2 * CLKS_PER_BIT);
		hold_line(1'b1, 1'b0, GAP_BITS * CLKS_PER_BIT);
	endtask

	task automatic clear_monitor();
		got_q.delete();
		done_cnt = 0;
		err_cnt = 0;
		rcv_cnt = 0;
	endtask

	task automatic wait_response();
		while (done_cnt + err_cnt == 0)
		begin
			@(posedge tb_clk);
		end
	endtask

	task automatic finish_test(input string name, input int errors);
		if (errors == 0)
		begin
			$display("PASS %s", name);
			pass_cnt++;
		end
		else
		begin
			$display("FAIL %s", name);
			fail_cnt++;
		end
	endtask

	task automatic check_count(input string name, input string what, input int want,
		input int got, inout int errors);
		if (got != want)
		begin
			$display("FAILED %s %s expected %0d actual %0d", name, what, want, got);
			errors++;
		end
	endtask

	task automatic check_idle();
		int errors;
		errors = 0;
		clear_monitor();
		hold_line(1'b1, 1'b0, 4 * CLKS_PER_BIT);
		check_count("reset_idle", "rcving cycles", 0, rcv_cnt, errors);
		check_count("reset_idle", "rx_strobe count", 0, got_q.size(), errors);
		check_count("reset_idle", "packet_done count", 0, done_cnt, errors);
		check_count("reset_idle", "rx_error count", 0, err_cnt, errors);
		finish_test("reset_idle", errors);
	endtask

	task automatic check_packet(input int idx);
		int errors;
		int i;
		int want_err;
		errors = 0;
		check_count(names[idx], "byte count", exp_bytes_v[idx], got_q.size(), errors);
		for (i = 0; i < got_q.size() && i < exp_bytes_v[idx]; i++)
		begin
			if (got_q[i] !== data_v[idx][i])
			begin
				$display("FAILED %s byte %0d expected %02h actual %02h", names[idx], i,
					data_v[idx][i], got_q[i]);
				errors++;
			end
		end
		want_err = (exp_err_v[idx] != 0) ? 1 : 0;
		check_count(names[idx], "packet_done count", 1 - want_err, done_cnt, errors);
		check_count(names[idx], "rx_error count", want_err, err_cnt, errors);
		finish_test(names[idx], errors);
	endtask

	initial
	begin
		int t;
		rst = 1'b1;
		d_plus = 1'b1;
		d_minus = 1'b0;
		seed = 27;
		cycle_cnt = 0;
		cycle_limit = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		clear_monitor();
		load_vectors();
		cycle_limit = vector_bits() * CLKS_PER_BIT * 2 + 1000;
		repeat (3) @(posedge tb_clk);
		rst <= 1'b0;
		check_idle();
		for (t = 0; t < num_tests; t++)
		begin
			clear_monitor();
			send_packet(t);
			wait_response();
			check_packet(t);
		end
		$display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
			fail_cnt);
		if (fail_cnt == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* tests/usb_rx_vectors.txt */
# name sync mode count data... eop_bits exp_bytes exp_err
# mode 0 normal, 1 no bit stuffing, 2 random 7 or 9 clock bits; eop_bits counts data bits
plain_short 80 0 1 a5 8 1 0
plain_multi 80 0 4 12 34 56 a5 32 4 0
stuff_ff 80 0 3 ff 01 ff 24 3 0
stuff_7e 80 0 3 7e 7e 3c 24 3 0
stuff_mix 80 0 4 ff 7e fe 00 32 4 0
sync_bad 84 0 2 12 34 16 0 1
stuff_violation 80 1 3 12 ff 00 24 1 1
eop_misaligned 80 0 3 c3 5a 81 19 2 1
jitter_short 80 2 4 55 5a 36 92 32 4 0
jitter_long 80 2 6 55 5a 36 92 4a 25 48 6 0

/* flist.f */
hw/usb_rx_pkg.sv
hw/usb_line_if.sv
hw/line_sampler.sv
hw/bit_timer.sv
hw/nrzi_decode.sv
hw/rx_control.sv
hw/usb_rx_top.sv
tests/tb_usb_rx.sv

/* Makefile */
.PHONY: simulate clean

simulate:
	verilator --binary --timing --top-module tb_usb_rx -f flist.f -o tb_usb_rx
	./obj_dir/tb_usb_rx | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
